/* second_pipe_consts.svh */
`ifndef SECOND_PIPE_CONSTS_SVH
`define SECOND_PIPE_CONSTS_SVH

// datapath widths
`define DATA_W          32
`define REG_ADDR_W      5
`define EXC_W           14
`define ALU_OP_W        5

// exception vector bit positions
`define EXC_OV_BIT      1
`define EXC_RI_BIT      2
`define EXC_IADDR_BIT   6

// primary opcodes, instr[31:26]
`define OPC_RTYPE       6'b000000
`define OPC_ADDI        6'b001000
`define OPC_ADDIU       6'b001001
`define OPC_SLTI        6'b001010
`define OPC_SLTIU       6'b001011
`define OPC_ANDI        6'b001100
`define OPC_ORI         6'b001101
`define OPC_XORI        6'b001110
`define OPC_LUI         6'b001111

// r-type function codes, instr[5:0]
`define FN_SLL          6'b000000
`define FN_SRL          6'b000010
`define FN_SRA          6'b000011
`define FN_SLLV         6'b000100
`define FN_SRLV         6'b000110
`define FN_SRAV         6'b000111
`define FN_ADD          6'b100000
`define FN_ADDU         6'b100001
`define FN_SUB          6'b100010
`define FN_SUBU         6'b100011
`define FN_AND          6'b100100
`define FN_OR           6'b100101
`define FN_XOR          6'b100110
`define FN_NOR          6'b100111
`define FN_SLT          6'b101010
`define FN_SLTU         6'b101011

// operand source select, a and b
`define SRC_RS_RT       2'b00
`define SRC_RS_IMM      2'b01
`define SRC_IMM_RT      2'b10

`endif

/* second_pipe_pkg.sv */
`include "second_pipe_consts.svh"

package second_pipe_pkg;

    // alu operations, immediate forms share the register ops
    typedef enum logic [`ALU_OP_W-1:0] {
        op_none = 5'd0,
        op_add  = 5'd1,
        op_addu = 5'd2,
        op_sub  = 5'd3,
        op_subu = 5'd4,
        op_slt  = 5'd5,
        op_sltu = 5'd6,
        op_and  = 5'd7,
        op_or   = 5'd8,
        op_xor  = 5'd9,
        op_nor  = 5'd10,
        op_sll  = 5'd11,
        op_srl  = 5'd12,
        op_sra  = 5'd13,
        op_lui  = 5'd14
    } alu_op_t;

    // decode to execute payload
    typedef struct packed {
        alu_op_t                op;
        logic [`DATA_W-1:0]     a;
        logic [`DATA_W-1:0]     b;
        logic                   wr_en;
        logic [`REG_ADDR_W-1:0] wr_addr;
        logic [`EXC_W-1:0]      exc;
    } dec_t;

    // execute to result payload
    typedef struct packed {
        logic                   wr_en;
        logic [`REG_ADDR_W-1:0] wr_addr;
        logic [`DATA_W-1:0]     wr_data;
        logic [`EXC_W-1:0]      exc;
    } res_t;

endpackage

/* issue_capture.sv */
`include "second_pipe_consts.svh"

module issue_capture (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_req,
    output logic                  in_ack,
    input  logic [`DATA_W-1:0]    instr,
    input  logic [`DATA_W-1:0]    pc,
    input  logic [`DATA_W-1:0]    rs_val,
    input  logic [`DATA_W-1:0]    rt_val,
    input  logic [`EXC_W-1:0]     exc_in,
    input  logic                  is_nop,
    output logic                  cap_valid,
    input  logic                  cap_ready,
    output logic [`DATA_W-1:0]    cap_instr,
    output logic [`DATA_W-1:0]    cap_pc,
    output logic [`DATA_W-1:0]    cap_rs_val,
    output logic [`DATA_W-1:0]    cap_rt_val,
    output logic [`EXC_W-1:0]     cap_exc,
    output logic                  cap_is_nop
);

    // idle -> holding on req, holding -> acked once taken downstream
    typedef enum logic [1:0] {st_idle, st_hold, st_acked} cap_state_t;

    cap_state_t state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:  if (in_req) state <= st_hold;
                st_hold:  if (cap_ready) state <= st_acked;
                // wait for the sender to drop req
                st_acked: if (!in_req) state <= st_idle;
                default:  state <= st_idle;
            endcase
        end
    end

    // payload copy, sender holds data stable while req is high
    always_ff @(posedge clk) begin
        if (state == st_idle && in_req) begin
            cap_instr  <= instr;
            cap_pc     <= pc;
            cap_rs_val <= rs_val;
            cap_rt_val <= rt_val;
            cap_exc    <= exc_in;
            cap_is_nop <= is_nop;
        end
    end

    assign cap_valid = (state == st_hold);
    // ack straight from state, so it is a registered output
    assign in_ack    = (state == st_acked);

endmodule

/* inst_decode.sv */
`include "second_pipe_consts.svh"

module inst_decode (
    input  logic [`DATA_W-1:0]   instr,
    input  logic [`DATA_W-1:0]   pc,
    input  logic [`DATA_W-1:0]   rs_val,
    input  logic [`DATA_W-1:0]   rt_val,
    input  logic [`EXC_W-1:0]    exc_in,
    input  logic                 is_nop,
    output second_pipe_pkg::dec_t dec
);

    // instruction fields
    logic [5:0]             opcode;
    logic [5:0]             funct;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [4:0]             shamt;
    logic [15:0]            imm16;

    // control from the opcode table
    second_pipe_pkg::alu_op_t op;
    logic [1:0]             src;
    logic                   sign_ext;
    logic                   use_rd;
    logic                   legal;
    logic [`DATA_W-1:0]     imm_ext;

    assign opcode = instr[31:26];
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign shamt  = instr[10:6];
    assign imm16  = instr[15:0];
    assign funct  = instr[5:0];

    always_comb begin
        op       = second_pipe_pkg::op_none;
        src      = `SRC_RS_RT;
        sign_ext = 1'b0;
        use_rd   = 1'b0;
        legal    = 1'b1;
        // a nop decodes to nothing and is never reserved
        if (!is_nop) begin
            case (opcode)
                `OPC_RTYPE: begin
                    use_rd = 1'b1;
                    case (funct)
                        `FN_ADD:  op = second_pipe_pkg::op_add;
                        `FN_ADDU: op = second_pipe_pkg::op_addu;
                        `FN_SUB:  op = second_pipe_pkg::op_sub;
                        `FN_SUBU: op = second_pipe_pkg::op_subu;
                        `FN_SLT:  op = second_pipe_pkg::op_slt;
                        `FN_SLTU: op = second_pipe_pkg::op_sltu;
                        `FN_AND:  op = second_pipe_pkg::op_and;
                        `FN_OR:   op = second_pipe_pkg::op_or;
                        `FN_XOR:  op = second_pipe_pkg::op_xor;
                        `FN_NOR:  op = second_pipe_pkg::op_nor;
                        `FN_SLLV: op = second_pipe_pkg::op_sll;
                        `FN_SRLV: op = second_pipe_pkg::op_srl;
                        `FN_SRAV: op = second_pipe_pkg::op_sra;
                        // fixed shifts take shamt as operand a
                        `FN_SLL: begin
                            op  = second_pipe_pkg::op_sll;
                            src = `SRC_IMM_RT;
                        end
                        `FN_SRL: begin
                            op  = second_pipe_pkg::op_srl;
                            src = `SRC_IMM_RT;
                        end
                        `FN_SRA: begin
                            op  = second_pipe_pkg::op_sra;
                            src = `SRC_IMM_RT;
                        end
                        default: legal = 1'b0;
                    endcase
                end
                `OPC_ADDI: begin
                    op       = second_pipe_pkg::op_add;
                    src      = `SRC_RS_IMM;
                    sign_ext = 1'b1;
                end
                `OPC_ADDIU: begin
                    op       = second_pipe_pkg::op_addu;
                    src      = `SRC_RS_IMM;
                    sign_ext = 1'b1;
                end
                `OPC_SLTI: begin
                    op       = second_pipe_pkg::op_slt;
                    src      = `SRC_RS_IMM;
                    sign_ext = 1'b1;
                end
                `OPC_SLTIU: begin
                    op       = second_pipe_pkg::op_sltu;
                    src      = `SRC_RS_IMM;
                    sign_ext = 1'b1;
                end
                // logical immediates are zero extended
                `OPC_ANDI: begin
                    op  = second_pipe_pkg::op_and;
                    src = `SRC_RS_IMM;
                end
                `OPC_ORI: begin
                    op  = second_pipe_pkg::op_or;
                    src = `SRC_RS_IMM;
                end
                `OPC_XORI: begin
                    op  = second_pipe_pkg::op_xor;
                    src = `SRC_RS_IMM;
                end
                `OPC_LUI: begin
                    op  = second_pipe_pkg::op_lui;
                    src = `SRC_IMM_RT;
                end
                default: legal = 1'b0;
            endcase
        end
    end

    // r-type immediate is only ever the shift amount
    assign imm_ext = (opcode == `OPC_RTYPE) ? {{(`DATA_W-5){1'b0}}, shamt} :
                     sign_ext ? {{(`DATA_W-16){imm16[15]}}, imm16} :
                     {{(`DATA_W-16){1'b0}}, imm16};

    always_comb begin
        dec.op      = op;
        dec.wr_en   = legal && !is_nop;
        // i-type writes rt, r-type writes rd
        dec.wr_addr = use_rd ? rd : rt;
        case (src)
            `SRC_RS_IMM: begin
                dec.a = rs_val;
                dec.b = imm_ext;
            end
            `SRC_IMM_RT: begin
                dec.a = imm_ext;
                dec.b = rt_val;
            end
            default: begin
                dec.a = rs_val;
                dec.b = rt_val;
            end
        endcase
        dec.exc = exc_in;
        if (!legal) dec.exc[`EXC_RI_BIT] = 1'b1;
        // misaligned fetch flags regardless of the opcode
        if (pc[1:0] != 2'b00) dec.exc[`EXC_IADDR_BIT] = 1'b1;
    end

endmodule

/* pipe_stage.sv */
module pipe_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // can take a new item when empty or draining this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    // payload only moves on an input transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data <= in_data;
        end
    end

endmodule

/* alu_execute.sv */
`include "second_pipe_consts.svh"

module alu_execute (
    input  second_pipe_pkg::dec_t dec,
    output second_pipe_pkg::res_t res
);

    logic [`DATA_W-1:0] sum;
    logic [`DATA_W-1:0] diff;
    logic [4:0]         sh;
    logic               add_ovf;
    logic               sub_ovf;
    logic [`DATA_W-1:0] result;
    logic               ovf;

    assign sum  = dec.a + dec.b;
    assign diff = dec.a - dec.b;
    // shift count from operand a, shifted value is operand b
    assign sh   = dec.a[4:0];

    // same-sign inputs with a sign change in the sum
    assign add_ovf = (dec.a[`DATA_W-1] == dec.b[`DATA_W-1]) &&
                     (sum[`DATA_W-1] != dec.a[`DATA_W-1]);
    // opposite-sign inputs with a sign change against a
    assign sub_ovf = (dec.a[`DATA_W-1] != dec.b[`DATA_W-1]) &&
                     (diff[`DATA_W-1] != dec.a[`DATA_W-1]);

    always_comb begin
        ovf = 1'b0;
        case (dec.op)
            second_pipe_pkg::op_add: begin
                result = sum;
                ovf    = add_ovf;
            end
            second_pipe_pkg::op_addu: result = sum;
            second_pipe_pkg::op_sub: begin
                result = diff;
                ovf    = sub_ovf;
            end
            second_pipe_pkg::op_subu: result = diff;
            second_pipe_pkg::op_slt:
                result = {{(`DATA_W-1){1'b0}}, ($signed(dec.a) < $signed(dec.b))};
            second_pipe_pkg::op_sltu:
                result = {{(`DATA_W-1){1'b0}}, (dec.a < dec.b)};
            second_pipe_pkg::op_and:  result = dec.a & dec.b;
            second_pipe_pkg::op_or:   result = dec.a | dec.b;
            second_pipe_pkg::op_xor:  result = dec.a ^ dec.b;
            second_pipe_pkg::op_nor:  result = ~(dec.a | dec.b);
            second_pipe_pkg::op_sll:  result = dec.b << sh;
            second_pipe_pkg::op_srl:  result = dec.b >> sh;
            second_pipe_pkg::op_sra:  result = $unsigned($signed(dec.b) >>> sh);
            // immediate arrives as operand a
            second_pipe_pkg::op_lui:  result = dec.a << 16;
            default:                  result = '0;
        endcase
    end

    always_comb begin
        res.wr_en   = dec.wr_en;
        res.wr_addr = dec.wr_addr;
        res.wr_data = result;
        res.exc     = dec.exc;
        // other exception bits pass through untouched
        if (ovf) res.exc[`EXC_OV_BIT] = 1'b1;
    end

endmodule

/* result_handshake.sv */
`include "second_pipe_consts.svh"

module result_handshake (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   res_valid,
    output logic                   res_ready,
    input  second_pipe_pkg::res_t  res,
    output logic                   out_req,
    input  logic                   out_ack,
    output logic                   wr_en,
    output logic [`REG_ADDR_W-1:0] wr_addr,
    output logic [`DATA_W-1:0]     wr_data,
    output logic [`EXC_W-1:0]      exc_out
);

    // idle -> req on accept, req -> release on ack, release -> idle on ack low
    typedef enum logic [1:0] {st_idle, st_req, st_release} out_state_t;

    out_state_t state;

    // a new result may enter as soon as ack is seen low again
    assign res_ready = (state == st_idle) || (state == st_release && !out_ack);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle:    if (res_valid) state <= st_req;
                st_req:     if (out_ack) state <= st_release;
                st_release: if (!out_ack) state <= res_valid ? st_req : st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    // held stable for the whole req phase
    always_ff @(posedge clk) begin
        if (res_valid && res_ready) begin
            // any exception kills the register write
            wr_en   <= res.wr_en && (res.exc == '0);
            wr_addr <= res.wr_addr;
            wr_data <= res.wr_data;
            exc_out <= res.exc;
        end
    end

    assign out_req = (state == st_req);

endmodule

/* second_pipe_top.sv */
`include "second_pipe_consts.svh"

module second_pipe_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_req,
    output logic                   in_ack,
    input  logic [`DATA_W-1:0]     instr,
    input  logic [`DATA_W-1:0]     pc,
    input  logic [`DATA_W-1:0]     rs_val,
    input  logic [`DATA_W-1:0]     rt_val,
    input  logic [`EXC_W-1:0]      exc_in,
    input  logic                   is_nop,
    output logic                   out_req,
    input  logic                   out_ack,
    output logic                   wr_en,
    output logic [`REG_ADDR_W-1:0] wr_addr,
    output logic [`DATA_W-1:0]     wr_data,
    output logic [`EXC_W-1:0]      exc_out
);

    // capture side
    logic                cap_valid;
    logic                cap_ready;
    logic [`DATA_W-1:0]  cap_instr;
    logic [`DATA_W-1:0]  cap_pc;
    logic [`DATA_W-1:0]  cap_rs_val;
    logic [`DATA_W-1:0]  cap_rt_val;
    logic [`EXC_W-1:0]   cap_exc;
    logic                cap_is_nop;

    // stage links
    second_pipe_pkg::dec_t dec_in;
    second_pipe_pkg::dec_t dec_q;
    second_pipe_pkg::res_t res_in;
    second_pipe_pkg::res_t res_q;
    logic                s1_valid;
    logic                s1_ready;
    logic                s2_valid;
    logic                s2_ready;

    issue_capture u_capture (
        .clk(clk), .reset(reset), .in_req(in_req), .in_ack(in_ack),
        .instr(instr), .pc(pc), .rs_val(rs_val), .rt_val(rt_val),
        .exc_in(exc_in), .is_nop(is_nop),
        .cap_valid(cap_valid), .cap_ready(cap_ready),
        .cap_instr(cap_instr), .cap_pc(cap_pc), .cap_rs_val(cap_rs_val),
        .cap_rt_val(cap_rt_val), .cap_exc(cap_exc), .cap_is_nop(cap_is_nop)
    );

    inst_decode u_decode (
        .instr(cap_instr), .pc(cap_pc), .rs_val(cap_rs_val), .rt_val(cap_rt_val),
        .exc_in(cap_exc), .is_nop(cap_is_nop), .dec(dec_in)
    );

    // stage 1 holds decoded operands
    pipe_stage #(.payload_t(second_pipe_pkg::dec_t)) u_stage1 (
        .clk(clk), .reset(reset),
        .in_valid(cap_valid), .in_ready(cap_ready), .in_data(dec_in),
        .out_valid(s1_valid), .out_ready(s1_ready), .out_data(dec_q)
    );

    alu_execute u_execute (
        .dec(dec_q), .res(res_in)
    );

    // stage 2 holds the alu result
    pipe_stage #(.payload_t(second_pipe_pkg::res_t)) u_stage2 (
        .clk(clk), .reset(reset),
        .in_valid(s1_valid), .in_ready(s1_ready), .in_data(res_in),
        .out_valid(s2_valid), .out_ready(s2_ready), .out_data(res_q)
    );

    result_handshake u_result (
        .clk(clk), .reset(reset),
        .res_valid(s2_valid), .res_ready(s2_ready), .res(res_q),
        .out_req(out_req), .out_ack(out_ack),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data), .exc_out(exc_out)
    );

endmodule

/* second_pipe_monitor.sv */
`include "second_pipe_consts.svh"

module second_pipe_monitor (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   in_ack,
    input  logic [`DATA_W-1:0]     instr,
    input  logic [`DATA_W-1:0]     pc,
    input  logic [`DATA_W-1:0]     rs_val,
    input  logic [`DATA_W-1:0]     rt_val,
    input  logic [`EXC_W-1:0]      exc_in,
    input  logic                   is_nop,
    input  logic                   out_req,
    input  logic                   wr_en,
    input  logic [`REG_ADDR_W-1:0] wr_addr,
    input  logic [`DATA_W-1:0]     wr_data,
    input  logic [`EXC_W-1:0]      exc_out,
    output int                     error_count,
    output int                     accept_count,
    output int                     result_count
);

    // one accepted instruction as seen on the input port
    typedef struct packed {
        logic [`DATA_W-1:0] instr;
        logic [`DATA_W-1:0] pc;
        logic [`DATA_W-1:0] rs;
        logic [`DATA_W-1:0] rt;
        logic [`EXC_W-1:0]  exc;
        logic               nop;
    } item_t;

    item_t                 pending [$];
    item_t                 cur;
    second_pipe_pkg::res_t want;
    logic                  in_ack_q;
    logic                  out_req_q;

    // reference model of decode, alu and write suppression
    function automatic second_pipe_pkg::res_t expect_result(input item_t it);
        logic [5:0]            opc;
        logic [5:0]            fn;
        logic [4:0]            shamt;
        logic [`DATA_W-1:0]    rs;
        logic [`DATA_W-1:0]    rt;
        logic [`DATA_W-1:0]    simm;
        logic [`DATA_W-1:0]    zimm;
        logic [`DATA_W:0]      wide;
        logic                  legal;
        logic                  ovf;
        second_pipe_pkg::res_t r;
        opc   = it.instr[31:26];
        fn    = it.instr[5:0];
        shamt = it.instr[10:6];
        rs    = it.rs;
        rt    = it.rt;
        simm  = {{16{it.instr[15]}}, it.instr[15:0]};
        zimm  = {16'h0000, it.instr[15:0]};
        legal = 1'b1;
        ovf   = 1'b0;
        r.wr_data = '0;
        // r-type writes rd, immediates write rt
        r.wr_addr = (opc == `OPC_RTYPE) ? it.instr[15:11] : it.instr[20:16];
        if (!it.nop && opc == `OPC_RTYPE) begin
            case (fn)
                `FN_ADD: begin
                    wide      = {rs[31], rs} + {rt[31], rt};
                    r.wr_data = wide[31:0];
                    ovf       = wide[32] ^ wide[31];
                end
                `FN_SUB: begin
                    wide      = {rs[31], rs} - {rt[31], rt};
                    r.wr_data = wide[31:0];
                    ovf       = wide[32] ^ wide[31];
                end
                `FN_ADDU: r.wr_data = rs + rt;
                `FN_SUBU: r.wr_data = rs - rt;
                `FN_SLT:  r.wr_data = ($signed(rs) < $signed(rt)) ? 32'd1 : 32'd0;
                `FN_SLTU: r.wr_data = (rs < rt) ? 32'd1 : 32'd0;
                `FN_AND:  r.wr_data = rs & rt;
                `FN_OR:   r.wr_data = rs | rt;
                `FN_XOR:  r.wr_data = rs ^ rt;
                `FN_NOR:  r.wr_data = ~(rs | rt);
                `FN_SLL:  r.wr_data = rt << shamt;
                `FN_SRL:  r.wr_data = rt >> shamt;
                `FN_SRA:  r.wr_data = $signed(rt) >>> shamt;
                `FN_SLLV: r.wr_data = rt << rs[4:0];
                `FN_SRLV: r.wr_data = rt >> rs[4:0];
                `FN_SRAV: r.wr_data = $signed(rt) >>> rs[4:0];
                default:  legal = 1'b0;
            endcase
        end else if (!it.nop) begin
            case (opc)
                `OPC_ADDI: begin
                    wide      = {rs[31], rs} + {simm[31], simm};
                    r.wr_data = wide[31:0];
                    ovf       = wide[32] ^ wide[31];
                end
                `OPC_ADDIU: r.wr_data = rs + simm;
                `OPC_SLTI:  r.wr_data = ($signed(rs) < $signed(simm)) ? 32'd1 : 32'd0;
                `OPC_SLTIU: r.wr_data = (rs < simm) ? 32'd1 : 32'd0;
                `OPC_ANDI:  r.wr_data = rs & zimm;
                `OPC_ORI:   r.wr_data = rs | zimm;
                `OPC_XORI:  r.wr_data = rs ^ zimm;
                `OPC_LUI:   r.wr_data = {it.instr[15:0], 16'h0000};
                default:    legal = 1'b0;
            endcase
        end
        r.exc = it.exc;
        if (!legal) r.exc[`EXC_RI_BIT] = 1'b1;
        if (it.pc[1:0] != 2'b00) r.exc[`EXC_IADDR_BIT] = 1'b1;
        if (ovf) r.exc[`EXC_OV_BIT] = 1'b1;
        // any raised bit, incoming or new, blocks the write
        r.wr_en = !it.nop && legal && (r.exc == '0);
        return r;
    endfunction

    always @(posedge clk) begin
        if (reset) begin
            in_ack_q     <= 1'b0;
            out_req_q    <= 1'b0;
            error_count  = 0;
            accept_count = 0;
            result_count = 0;
            pending.delete();
        end else begin
            in_ack_q  <= in_ack;
            out_req_q <= out_req;
            // input fields are still held while ack rises
            if (in_ack && !in_ack_q) begin
                cur = {instr, pc, rs_val, rt_val, exc_in, is_nop};
                pending.push_back(cur);
                accept_count++;
            end
            if (out_req && !out_req_q) begin
                result_count++;
                if (pending.size() == 0) begin
                    error_count++;
                    $display("error at %0t: result returned with no instruction pending",
                             $time);
                end else begin
                    cur  = pending.pop_front();
                    want = expect_result(cur);
                    if (wr_en !== want.wr_en) begin
                        error_count++;
                        $display("error at %0t: instr %h wr_en %b, expected %b",
                                 $time, cur.instr, wr_en, want.wr_en);
                    end
                    if (exc_out !== want.exc) begin
                        error_count++;
                        $display("error at %0t: instr %h exc_out %h, expected %h",
                                 $time, cur.instr, exc_out, want.exc);
                    end
                    // address and data only matter on a write
                    if (want.wr_en && wr_addr !== want.wr_addr) begin
                        error_count++;
                        $display("error at %0t: instr %h wr_addr %0d, expected %0d",
                                 $time, cur.instr, wr_addr, want.wr_addr);
                    end
                    if (want.wr_en && wr_data !== want.wr_data) begin
                        error_count++;
                        $display("error at %0t: instr %h wr_data %h, expected %h",
                                 $time, cur.instr, wr_data, want.wr_data);
                    end
                end
            end
        end
    end

endmodule

/* second_pipe_checker.sv */
`include "second_pipe_consts.svh"

module second_pipe_checker (
    input logic                   clk,
    input logic                   reset,
    input logic                   in_req,
    input logic                   in_ack,
    input logic                   out_req,
    input logic                   out_ack,
    input logic                   wr_en,
    input logic [`REG_ADDR_W-1:0] wr_addr,
    input logic [`DATA_W-1:0]     wr_data,
    input logic [`EXC_W-1:0]      exc_out
);

    int assert_fails = 0;

    // ack answers a request that was already up
    ack_after_req: assert property (@(posedge clk) disable iff (reset)
        $rose(in_ack) |-> $past(in_req))
    else begin
        assert_fails++;
        $error("in_ack rose without a pending in_req");
    end

    // req and result held until the consumer acks
    req_held: assert property (@(posedge clk) disable iff (reset)
        (out_req && !out_ack) |=> (out_req && $stable(wr_en) && $stable(wr_addr) &&
                                   $stable(wr_data) && $stable(exc_out)))
    else begin
        assert_fails++;
        $error("out_req or result changed before out_ack");
    end

    // both handshakes idle coming out of reset
    idle_after_reset: assert property (@(posedge clk)
        reset |=> (!in_ack && !out_req))
    else begin
        assert_fails++;
        $error("in_ack or out_req high after reset");
    end

endmodule

bind second_pipe_top second_pipe_checker chk (
    .clk(clk), .reset(reset), .in_req(in_req), .in_ack(in_ack),
    .out_req(out_req), .out_ack(out_ack), .wr_en(wr_en), .wr_addr(wr_addr),
    .wr_data(wr_data), .exc_out(exc_out)
);

/* second_pipe_tb.sv */
`include "second_pipe_consts.svh"

module second_pipe_tb;

    localparam int num_instr  = 300;
    localparam int clk_period = 40;

    logic                   clk;
    logic                   reset;
    logic                   in_req;
    logic                   in_ack;
    logic [`DATA_W-1:0]     instr;
    logic [`DATA_W-1:0]     pc;
    logic [`DATA_W-1:0]     rs_val;
    logic [`DATA_W-1:0]     rt_val;
    logic [`EXC_W-1:0]      exc_in;
    logic                   is_nop;
    logic                   out_req;
    logic                   out_ack;
    logic                   wr_en;
    logic [`REG_ADDR_W-1:0] wr_addr;
    logic [`DATA_W-1:0]     wr_data;
    logic [`EXC_W-1:0]      exc_out;
    int                     error_count;
    int                     accept_count;
    int                     result_count;
    int                     total_errors;
    integer                 seed;

    // kept encodings to draw legal instructions from
    logic [5:0]             legal_fn [16];
    logic [5:0]             legal_opc [8];

    second_pipe_top uut (.*);

    second_pipe_monitor mon (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // uniform draw in 0 .. n-1 from the shared seed
    function automatic int draw(input int n);
        draw = $unsigned($random(seed)) % n;
    endfunction

    // one four-phase input transfer starting on a falling edge
    task automatic send_instr();
        int                 kind;
        int                 idx;
        logic [`DATA_W-1:0] rnd;
        kind  = draw(100);
        instr = $random(seed);
        if (kind < 10) begin
            // lw, j, mult and syscall lie outside the kept set
            idx = draw(4);
            case (idx)
                0: instr[31:26] = 6'b100011;
                1: instr[31:26] = 6'b000010;
                2: begin
                    instr[31:26] = `OPC_RTYPE;
                    instr[5:0]   = 6'b011000;
                end
                default: begin
                    instr[31:26] = `OPC_RTYPE;
                    instr[5:0]   = 6'b001100;
                end
            endcase
        end else begin
            idx = draw(24);
            if (idx < 16) begin
                instr[31:26] = `OPC_RTYPE;
                instr[5:0]   = legal_fn[idx];
            end else begin
                instr[31:26] = legal_opc[idx - 16];
            end
        end
        pc = $random(seed);
        // about one pc in ten misaligned
        if (draw(100) >= 10) begin
            pc[1:0] = 2'b00;
        end else if (pc[1:0] == 2'b00) begin
            pc[1:0] = 2'b10;
        end
        rs_val = $random(seed);
        rt_val = $random(seed);
        // mostly clean exception vectors so writes get through
        rnd    = $random(seed);
        exc_in = (draw(100) < 20) ? rnd[`EXC_W-1:0] : '0;
        is_nop = (draw(100) < 5);
        in_req = 1'b1;
        @(negedge clk);
        while (!in_ack) @(negedge clk);
        in_req = 1'b0;
        while (in_ack) @(negedge clk);
    endtask

    // output side acknowledger with random back-pressure
    initial begin
        int delay;
        out_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (out_req) begin
                delay = draw(6);
                repeat (delay) @(negedge clk);
                out_ack = 1'b1;
                @(negedge clk);
                while (out_req) @(negedge clk);
                out_ack = 1'b0;
            end
        end
    end

    initial begin
        seed      = 32'h871;
        reset     = 1'b1;
        in_req    = 1'b0;
        instr     = '0;
        pc        = '0;
        rs_val    = '0;
        rt_val    = '0;
        exc_in    = '0;
        is_nop    = 1'b0;
        legal_fn  = '{`FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV,
                      `FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_AND, `FN_OR,
                      `FN_XOR, `FN_NOR, `FN_SLT, `FN_SLTU};
        legal_opc = '{`OPC_ADDI, `OPC_ADDIU, `OPC_SLTI, `OPC_SLTIU,
                      `OPC_ANDI, `OPC_ORI, `OPC_XORI, `OPC_LUI};
        repeat (10) @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < num_instr; i++) begin
            send_instr();
        end
        // let the last results drain out
        wait (result_count == num_instr);
        repeat (10) @(negedge clk);
        total_errors = error_count + uut.chk.assert_fails;
        if (accept_count != num_instr) begin
            $display("accepted %0d instructions but %0d were sent", accept_count, num_instr);
            total_errors++;
        end
        $display("errors %0d, transactions %0d", total_errors, result_count);
        if (total_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // 30 cycles per instruction is far beyond the worst back-pressure
    initial begin
        #(num_instr * 30 * clk_period);
        $display("timeout: only %0d of %0d results came back", result_count, num_instr);
        $display("Regression failed");
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
second_pipe_pkg.sv
issue_capture.sv
inst_decode.sv
pipe_stage.sv
alu_execute.sv
result_handshake.sv
second_pipe_top.sv
second_pipe_monitor.sv
second_pipe_checker.sv
second_pipe_tb.sv
